//--- vlog.f
+incdir+verilog
verilog/fir_axil_pkg.sv
verilog/fir_stream_pkg.sv
verilog/fir_if.sv
verilog/fir_ctrl_regs.sv
verilog/fir_sample_line.sv
verilog/fir_mac_engine.sv
verilog/fir_top.sv
tb/fir_tb_clk.sv
tb/fir_assertions.sv
tb/fir_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -Mdir obj_dir
TOP       = fir_tb
FILELIST  = vlog.f
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tb/fir_tb.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_tb import fir_axil_pkg::*, fir_stream_pkg::*; ();

    localparam int num_cases = 5;
    localparam int max_len   = 64;
    localparam int limit     = 1000;
    // taps, data length and random sm_tready per case
    localparam int case_taps [num_cases] = '{1, 4, 11, 32, 7};
    localparam int case_len  [num_cases] = '{6, 20, 40, 45, 12};
    localparam bit case_rnd  [num_cases] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid, awready, wvalid, wready;
    logic                   arvalid, arready, rvalid, rready;
    logic [`FIR_ADDR_W-1:0] awaddr, araddr;
    logic [`FIR_DATA_W-1:0] wdata, rdata;
    logic                   ss_tvalid, ss_tready, ss_tlast;
    logic                   sm_tvalid, sm_tready, sm_tlast;
    sample_t                ss_tdata, sm_tdata;

    coef_t       h [`FIR_MAX_TAPS];
    sample_t     x [max_len];
    sample_t     y_exp [max_len];
    logic [31:0] rand_state = 32'h43b5;
    logic [31:0] word;
    int          errors, case_errors, checks, tests_run, poll;
    bit          hung;

    fir_tb_clk u_clk (.axis_clk(axis_clk));

    fir_top dut (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .ss_tvalid(ss_tvalid), .ss_tready(ss_tready), .ss_tdata(ss_tdata), .ss_tlast(ss_tlast),
        .sm_tvalid(sm_tvalid), .sm_tready(sm_tready), .sm_tdata(sm_tdata), .sm_tlast(sm_tlast)
    );

    // LCG with the numerical recipes constants
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // register 0x00 has ap_start, ap_done and ap_idle in bits 0 to 2
    // stream bits expected low
    function automatic logic [31:0] status_word(input logic idle, input logic done);
        return {29'b0, idle, done, 1'b0};
    endfunction

    task automatic report_hang(input string what);
        hung = 1'b1;
        $display("Timed out after %0d cycles waiting for %s at %0t ns", limit, what, $time);
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            case_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic write_reg(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] data);
        int cnt;
        if (hung) return;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cnt     = 0;
        while (!(awready && wready) && cnt < limit) begin
            @(negedge axis_clk);
            cnt++;
        end
        if (!(awready && wready)) report_hang("awready and wready");
        // transfer on the edge in between
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input logic [`FIR_ADDR_W-1:0] addr, output logic [31:0] data);
        int cnt;
        data = 'x;
        if (hung) return;
        araddr  = addr;
        arvalid = 1'b1;
        cnt     = 0;
        while (!arready && cnt < limit) begin
            @(negedge axis_clk);
            cnt++;
        end
        if (!arready) report_hang("arready");
        @(negedge axis_clk);
        arvalid = 1'b0;
        cnt     = 0;
        while (!rvalid && cnt < limit) begin
            @(negedge axis_clk);
            cnt++;
        end
        if (!rvalid) report_hang("rvalid");
        // one stall cycle before taking the data
        @(negedge axis_clk);
        data   = rdata;
        rready = 1'b1;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic send_samples(input int n);
        int cnt;
        for (int i = 0; i < n && !hung; i++) begin
            ss_tdata  = x[i];
            ss_tvalid = 1'b1;
            cnt       = 0;
            while (!ss_tready && cnt < limit) begin
                @(negedge axis_clk);
                cnt++;
            end
            if (!ss_tready) report_hang("ss_tready");
            @(negedge axis_clk);
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int n, input bit rnd);
        int          cnt;
        bit          got;
        logic [31:0] r;
        for (int i = 0; i < n && !hung; i++) begin
            got = 1'b0;
            cnt = 0;
            while (!got && cnt < limit) begin
                @(negedge axis_clk);
                r         = next_rand();
                sm_tready = rnd ? r[30] : 1'b1;
                got       = sm_tvalid && sm_tready;
                cnt++;
            end
            if (!got) begin
                report_hang("sm_tvalid");
            end else begin
                check_word(sm_tdata, y_exp[i], $sformatf("y[%0d]", i));
                check_word({31'b0, sm_tlast}, {31'b0, i == n - 1},
                           $sformatf("sm_tlast at y[%0d]", i));
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    task automatic run_case(input int c);
        int      taps;
        int      len;
        sample_t acc;
        taps        = case_taps[c];
        len         = case_len[c];
        case_errors = 0;
        for (int k = 0; k < taps; k++) h[k] = next_rand();
        for (int i = 0; i < len; i++) x[i] = next_rand();
        // reference model where x before the first sample is zero
        for (int n = 0; n < len; n++) begin
            acc = '0;
            for (int k = 0; k < taps && k <= n; k++) begin
                acc = acc + h[k] * x[n - k];
            end
            y_exp[n] = acc;
        end
        write_reg(`FIR_REG_LEN, len);
        write_reg(`FIR_REG_TAPS, taps);
        for (int k = 0; k < taps; k++) write_reg(12'(`FIR_TAP_BASE + 4 * k), h[k]);
        read_reg(`FIR_REG_LEN, word);
        check_word(word, len, "data_length readback");
        read_reg(`FIR_REG_TAPS, word);
        check_word(word, taps, "tap_num readback");
        for (int k = 0; k < taps; k++) begin
            read_reg(12'(`FIR_TAP_BASE + 4 * k), word);
            check_word(word, h[k], $sformatf("coefficient %0d readback", k));
        end
        write_reg(`FIR_REG_CTRL, 32'h1);
        // config locked while calc runs
        write_reg(`FIR_REG_TAPS, taps + 1);
        read_reg(`FIR_REG_TAPS, word);
        check_word(word, taps, "tap_num during calc");
        read_reg(`FIR_TAP_BASE, word);
        check_word(word, 32'hffff_ffff, "coefficient read during calc");
        fork
            send_samples(len);
            collect_outputs(len, case_rnd[c]);
        join
        poll = 0;
        word = '0;
        while (!word[1] && poll < limit && !hung) begin
            read_reg(`FIR_REG_CTRL, word);
            poll++;
        end
        if (!word[1] && !hung) report_hang("ap_done");
        check_word(word, status_word(1'b0, 1'b1), "status at end of run");
        // that read acknowledged done
        read_reg(`FIR_REG_CTRL, word);
        check_word(word, status_word(1'b1, 1'b0), "status after done read");
        tests_run++;
        $display("test %0d: taps %0d, length %0d, random ready %0d: %s",
                 c, taps, len, case_rnd[c], (case_errors == 0 && !hung) ? "pass" : "fail");
    endtask

    initial begin
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        awaddr     = '0;
        araddr     = '0;
        wdata      = '0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        axis_rst_n = 1'b0;
        repeat (10) @(negedge axis_clk);
        axis_rst_n = 1'b1;
        @(negedge axis_clk);
        // every ready and valid driven by the DUT starts low
        check_word({26'b0, awready, wready, arready, rvalid, ss_tready, sm_tvalid}, '0,
                   "handshake outputs after reset");
        // only ap_idle after reset
        read_reg(`FIR_REG_CTRL, word);
        check_word(word, status_word(1'b1, 1'b0), "status after reset");
        for (int c = 0; c < num_cases && !hung; c++) begin
            run_case(c);
        end
        errors += dut.u_fir_assertions.fail_count;
        $display("tests %0d of %0d, checks %0d, errors %0d",
                 tests_run, num_cases, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tb/fir_assertions.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_assertions (
    input logic                   axis_clk,
    input logic                   axis_rst_n,
    input logic                   awready,
    input logic                   wready,
    input logic                   rvalid,
    input logic                   rready,
    input logic [`FIR_DATA_W-1:0] rdata,
    input logic                   sm_tvalid,
    input logic                   sm_tready,
    input logic [`FIR_DATA_W-1:0] sm_tdata,
    input logic                   sm_tlast
);

    // number of failed assertions
    int fail_count;

    // write readies are single-cycle pulses
    aw_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready |=> !awready)
        else begin
            $error("awready held longer than one cycle");
            fail_count++;
        end
    w_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        wready |=> !wready)
        else begin
            $error("wready held longer than one cycle");
            fail_count++;
        end

    // read data parked until the master takes it
    r_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            fail_count++;
        end

    // y held under back-pressure
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
        else begin
            $error("output stream changed while stalled");
            fail_count++;
        end

endmodule

bind fir_top fir_assertions u_fir_assertions (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awready    (awready),
    .wready     (wready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast)
);

//--- tb/fir_tb_clk.sv
`timescale 1ns/1ps

module fir_tb_clk #(
    // half of the 4 ns period
    parameter int half_ns = 2
) (
    output logic axis_clk
);

    initial begin
        axis_clk = 1'b0;
    end

    // free running, never stopped
    always #(half_ns) axis_clk = ~axis_clk;

endmodule

//--- verilog/fir_top.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_top (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    // register port
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`FIR_DATA_W-1:0] wdata,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    // x input stream
    input  logic                   ss_tvalid,
    output logic                   ss_tready,
    input  logic [`FIR_DATA_W-1:0] ss_tdata,
    // run length comes from data_length, this one is not looked at
    input  logic                   ss_tlast,
    // y output stream
    output logic                   sm_tvalid,
    input  logic                   sm_tready,
    output logic [`FIR_DATA_W-1:0] sm_tdata,
    output logic                   sm_tlast
);

    fir_cfg_if  cfg_bus ();
    fir_hist_if hist_bus ();

    // register map, run FSM, tap storage
    fir_ctrl_regs u_ctrl_regs (
        .axis_clk      (axis_clk),
        .axis_rst_n    (axis_rst_n),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        // stream status bits of register 0x00
        .ss_tready_mon (ss_tready),
        .sm_tvalid_mon (sm_tvalid),
        .cfg           (cfg_bus.ctrl)
    );

    // input side and history
    fir_sample_line u_sample_line (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .cfg        (cfg_bus.sample),
        .hist       (hist_bus.line)
    );

    // MAC and output register
    fir_mac_engine u_mac_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .cfg        (cfg_bus.engine),
        .hist       (hist_bus.engine)
    );

endmodule

//--- verilog/fir_mac_engine.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_mac_engine import fir_stream_pkg::*; (
    input  logic    axis_clk,
    input  logic    axis_rst_n,
    input  logic    sm_tready,
    output logic    sm_tvalid,
    output sample_t sm_tdata,
    output logic    sm_tlast,
    fir_cfg_if.engine  cfg,
    fir_hist_if.engine hist
);

    logic                   mac_busy;
    logic                   load_now;
    tap_idx_t               k;
    tap_idx_t               last_k;
    sample_t                acc;
    sample_t                prod;
    logic [`FIR_DATA_W-1:0] y_cnt;
    logic                   consume;
    logic                   out_hold;

    assign last_k = tap_idx_t'(cfg.tap_num - 32'd1);

    // output register stalled by the sink
    assign out_hold = sm_tvalid && !sm_tready;

    // take the next sample only when idle and the output slot will be free
    assign consume = cfg.run && hist.x_valid && !mac_busy && !load_now && !out_hold;
    assign hist.x_ready = consume;

    // x[n-k], index wr_pos minus k wrapped at tap_num
    always_comb begin
        if (k <= hist.wr_pos) begin
            hist.rd_idx = hist.wr_pos - k;
        end else begin
            hist.rd_idx = tap_idx_t'(cfg.tap_num + hist.wr_pos - k);
        end
    end

    assign cfg.coef_idx = k;

    // sequencer and output handshake
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            mac_busy  <= 1'b0;
            load_now  <= 1'b0;
            k         <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            y_cnt     <= '0;
        end else if (cfg.start_pulse) begin
            mac_busy  <= 1'b0;
            load_now  <= 1'b0;
            k         <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            y_cnt     <= '0;
        end else begin
            if (consume) begin
                mac_busy <= 1'b1;
                k        <= '0;
            end else if (mac_busy) begin
                // tap_num read cycles, then one load cycle
                if (k == last_k) begin
                    mac_busy <= 1'b0;
                    load_now <= 1'b1;
                end else begin
                    k <= k + 1'b1;
                end
            end
            if (load_now) begin
                load_now  <= 1'b0;
                sm_tvalid <= 1'b1;
                sm_tlast  <= (y_cnt + 1'b1 == cfg.data_length);
                y_cnt     <= y_cnt + 1'b1;
            end else if (sm_tvalid && sm_tready) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

    // product registered, summed one cycle later
    // the last product is folded in while loading the output
    always_ff @(posedge axis_clk) begin
        if (consume) begin
            acc  <= '0;
            prod <= '0;
        end else if (mac_busy) begin
            acc  <= acc + prod;
            prod <= hist.rd_data * cfg.coef;
        end
        if (load_now) begin
            sm_tdata <= acc + prod;
        end
    end

    // final y accepted by the sink
    assign cfg.run_last = sm_tvalid && sm_tready && sm_tlast;

endmodule

//--- verilog/fir_sample_line.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_sample_line import fir_stream_pkg::*; (
    input  logic    axis_clk,
    input  logic    axis_rst_n,
    input  logic    ss_tvalid,
    input  sample_t ss_tdata,
    output logic    ss_tready,
    fir_cfg_if.sample cfg,
    fir_hist_if.line  hist
);

    sample_t                hist_mem [`FIR_MAX_TAPS];
    sample_t                stage;
    logic                   x_valid;
    tap_idx_t               wr_pos;
    tap_idx_t               last_pos;
    tap_idx_t               next_pos;
    logic [`FIR_DATA_W-1:0] in_cnt;
    logic                   accept;

    // history wraps at tap_num
    assign last_pos = tap_idx_t'(cfg.tap_num - 32'd1);
    assign next_pos = (wr_pos == last_pos) ? '0 : wr_pos + 1'b1;

    // one staged sample at most, stop once data_length samples are in
    assign ss_tready = cfg.run && !cfg.start_pulse && !x_valid && (in_cnt < cfg.data_length);
    assign accept    = ss_tvalid && ss_tready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            x_valid <= 1'b0;
            wr_pos  <= '0;
            in_cnt  <= '0;
        end else if (cfg.start_pulse) begin
            x_valid <= 1'b0;
            // first sample then lands at position 0
            wr_pos  <= last_pos;
            in_cnt  <= '0;
        end else if (accept) begin
            x_valid <= 1'b1;
            in_cnt  <= in_cnt + 1'b1;
        end else if (hist.x_ready) begin
            x_valid <= 1'b0;
            wr_pos  <= next_pos;
        end
    end

    // sample enters the history only when the engine takes it,
    // so a waiting sample never overwrites the oldest tap in use
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            stage <= ss_tdata;
        end
        if (cfg.start_pulse) begin
            // samples before the first one count as zero
            for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
                hist_mem[i] <= '0;
            end
        end else if (hist.x_ready) begin
            hist_mem[next_pos] <= stage;
        end
    end

    assign hist.x_valid = x_valid;
    assign hist.wr_pos  = wr_pos;
    assign hist.rd_data = hist_mem[hist.rd_idx];

endmodule

//--- verilog/fir_ctrl_regs.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_ctrl_regs import fir_axil_pkg::*, fir_stream_pkg::*; (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [`FIR_DATA_W-1:0] wdata,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    input  logic                   ss_tready_mon,
    input  logic                   sm_tvalid_mon,
    fir_cfg_if.ctrl                cfg
);

    run_state_t             state;
    logic                   start_pulse;
    logic [`FIR_DATA_W-1:0] data_length;
    logic [`FIR_DATA_W-1:0] tap_num;
    coef_t                  coefs [`FIR_MAX_TAPS];
    logic [`FIR_ADDR_W-1:0] rd_addr;
    logic                   wr_fire;
    logic                   cfg_wr;
    logic                   ar_fire;
    logic                   aw_is_tap;
    logic                   ar_is_tap;
    ctrl_word_u             ctrl_word;
    logic [`FIR_DATA_W-1:0] rd_word;

    // write lands on the edge where both ready pulses are up
    assign wr_fire   = awvalid && wvalid && awready && wready;
    // length, taps and coefficients only change while idle
    assign cfg_wr    = wr_fire && (state == RUN_IDLE);
    assign ar_fire   = arvalid && arready;
    assign aw_is_tap = (awaddr >= `FIR_TAP_BASE) && (awaddr <= `FIR_TAP_LAST);
    assign ar_is_tap = (araddr >= `FIR_TAP_BASE) && (araddr <= `FIR_TAP_LAST);

    // bus handshakes, one-cycle ready pulses
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready;
            wready  <= awvalid && wvalid && !wready;
            // no new address while a read is still pending
            arready <= arvalid && !arready && !rvalid;
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // run FSM and config registers
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state       <= RUN_IDLE;
            start_pulse <= 1'b0;
            data_length <= '0;
            tap_num     <= '0;
        end else begin
            start_pulse <= cfg_wr && (awaddr == `FIR_REG_CTRL) && wdata[0];
            if (cfg_wr && (awaddr == `FIR_REG_LEN)) begin
                data_length <= wdata;
            end
            if (cfg_wr && (awaddr == `FIR_REG_TAPS)) begin
                tap_num <= wdata;
            end
            case (state)
                RUN_IDLE: if (cfg_wr && (awaddr == `FIR_REG_CTRL) && wdata[0]) state <= RUN_CALC;
                RUN_CALC: if (cfg.run_last) state <= RUN_DONE;
                // software acknowledges by reading status
                RUN_DONE: if (rvalid && rready && (rd_addr == `FIR_REG_CTRL)) state <= RUN_IDLE;
                default:  state <= RUN_IDLE;
            endcase
        end
    end

    // tap storage
    always_ff @(posedge axis_clk) begin
        if (cfg_wr && aw_is_tap) begin
            coefs[tap_idx_t'(awaddr[$bits(tap_idx_t)+1:2])] <= wdata;
        end
    end

    // status word, reserved bits zero
    always_comb begin
        ctrl_word.raw_word              = '0;
        ctrl_word.ctrl.ap_start         = start_pulse;
        ctrl_word.ctrl.ap_done          = (state == RUN_DONE);
        ctrl_word.ctrl.ap_idle          = (state == RUN_IDLE);
        ctrl_word.ctrl.stream_in_ready  = ss_tready_mon;
        ctrl_word.ctrl.stream_out_ready = sm_tvalid_mon;
    end

    // read mux, unmapped reads give all ones
    always_comb begin
        rd_word = '1;
        if (araddr == `FIR_REG_CTRL) begin
            rd_word = ctrl_word.raw_word;
        end else if (araddr == `FIR_REG_LEN) begin
            rd_word = data_length;
        end else if (araddr == `FIR_REG_TAPS) begin
            rd_word = tap_num;
        end else if (ar_is_tap && (state == RUN_IDLE)) begin
            rd_word = coefs[tap_idx_t'(araddr[$bits(tap_idx_t)+1:2])];
        end
    end

    // captured at the address handshake so rdata holds until rready
    always_ff @(posedge axis_clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
            rdata   <= rd_word;
        end
    end

    assign cfg.run         = (state == RUN_CALC);
    assign cfg.start_pulse = start_pulse;
    assign cfg.data_length = data_length;
    assign cfg.tap_num     = tap_num;
    // engine side coefficient lookup
    assign cfg.coef        = coefs[cfg.coef_idx];

endmodule

//--- verilog/fir_if.sv
`timescale 1ns/1ps
`include "fir_settings.svh"

// configuration from the register block to the data path
interface fir_cfg_if import fir_stream_pkg::*; ();
    logic                   run;
    logic                   start_pulse;
    logic [`FIR_DATA_W-1:0] data_length;
    logic [`FIR_DATA_W-1:0] tap_num;
    // tap lookup, index from engine and word back
    tap_idx_t               coef_idx;
    coef_t                  coef;
    // final y handshake
    logic                   run_last;

    modport ctrl (output run, start_pulse, data_length, tap_num, coef,
                  input coef_idx, run_last);
    modport sample (input run, start_pulse, data_length, tap_num);
    modport engine (input run, start_pulse, data_length, tap_num, coef,
                    output coef_idx, run_last);
endinterface

// history port between the sample line and the engine
interface fir_hist_if import fir_stream_pkg::*; ();
    // sample staged, waiting for the engine
    logic     x_valid;
    logic     x_ready;
    // newest sample position
    tap_idx_t wr_pos;
    // random read by the engine
    tap_idx_t rd_idx;
    sample_t  rd_data;

    modport line (output x_valid, wr_pos, rd_data,
                  input x_ready, rd_idx);
    modport engine (input x_valid, wr_pos, rd_data,
                    output x_ready, rd_idx);
endinterface

//--- verilog/fir_stream_pkg.sv
`include "fir_settings.svh"

package fir_stream_pkg;

    // x sample in, y value out
    typedef logic [`FIR_DATA_W-1:0] sample_t;

    // filter coefficient h[k]
    typedef logic [`FIR_DATA_W-1:0] coef_t;

    // index into tap storage or the history
    // 5 bits for 32 entries
    typedef logic [$clog2(`FIR_MAX_TAPS)-1:0] tap_idx_t;

endpackage

//--- verilog/fir_axil_pkg.sv
`include "fir_settings.svh"

package fir_axil_pkg;

    // run state of the filter
    typedef enum logic [1:0] {
        RUN_IDLE = 2'b00,
        RUN_CALC = 2'b01,
        RUN_DONE = 2'b10
    } run_state_t;

    // register 0x00 as seen by software
    // bit 0 is the last field in the list below
    typedef struct packed {
        logic [`FIR_DATA_W-7:0] rsvd_hi;
        logic                   stream_out_ready;
        logic                   stream_in_ready;
        // bit 3 always reads 0
        logic                   rsvd_3;
        logic                   ap_idle;
        logic                   ap_done;
        logic                   ap_start;
    } ap_ctrl_t;

    // same word either raw for the read mux or split into fields
    typedef union packed {
        logic [`FIR_DATA_W-1:0] raw_word;
        ap_ctrl_t               ctrl;
    } ctrl_word_u;

endpackage

//--- verilog/fir_settings.svh
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// data word width on both streams and the register bus
`define FIR_DATA_W 32

// register address width
`define FIR_ADDR_W 12

// tap storage depth, also the depth of the sample history
`define FIR_MAX_TAPS 32

// control and status word
`define FIR_REG_CTRL 12'h000
// number of x samples per run
`define FIR_REG_LEN 12'h010
// number of active taps
`define FIR_REG_TAPS 12'h014

// coefficient window, one word per tap
`define FIR_TAP_BASE 12'h080
`define FIR_TAP_LAST 12'h0FF

`endif
